// File: all.f
+incdir+dv
hdl/mips_cp0_pkg.sv
hdl/cp0_regs.sv
hdl/cp0_timer.sv
hdl/cp0_int_ctrl.sv
hdl/cp0_excp_unit.sv
hdl/cp0_top.sv
dv/tb_cp0.sv

// File: dv/tb_cp0_model.svh
`ifndef TB_CP0_MODEL_SVH
`define TB_CP0_MODEL_SVH

// reference copy of cp0 state, advanced once per clock edge
logic       m_ie, m_exl, m_bd, m_timer, m_held;
int_vec_t   m_im;
exc_code_t  m_code;
logic [1:0] m_ip_sw;
logic [4:0] m_ext_q;
word_t      m_epc, m_badvaddr, m_count, m_compare;
logic [2:0] m_k0;
int         m_div;

// ExcCode by flag position, last entry for an empty flag set or an interrupt
localparam exc_code_t FLAG_CODE [8] = '{EXC_ADEL, EXC_RI, EXC_OV, EXC_BP, EXC_SYS,
	EXC_ADEL, EXC_ADES, EXC_INT};

task automatic model_reset();
	{m_ie, m_exl, m_bd, m_timer, m_held} = '0;
	{m_im, m_code, m_ip_sw, m_ext_q} = '0;
	{m_epc, m_badvaddr, m_count, m_compare} = '0;
	m_k0 = CONFIG_RESET[2:0];
	m_div = 0;
endtask

function automatic logic m_request();
	int_vec_t ip;
	// recorded IP bits plus the live hardware lines
	ip = {m_timer, m_ext_q, m_ip_sw} | {ext_int, 2'b00};
	return m_ie && !m_exl && (|(ip & m_im));
endfunction

function automatic logic m_int_hit();
	return inter_valid && (m_request() || m_held) && !m_exl;
endfunction

function automatic int first_flag();
	for (int i = 0; i < 7; i++) begin
		if (excp_flags[i])
			return i;
	end
	return 7;
endfunction

function automatic word_t m_read(reg_addr_t a);
	word_t w;
	w = '0;
	if (a[2:0] == 3'b000) begin
		case (a[7:3])
			ADDR_BADVADDR: w = m_badvaddr;
			ADDR_COUNT:    w = m_count;
			ADDR_COMPARE:  w = m_compare;
			ADDR_STATUS:   w = {16'h0, m_im, 6'h0, m_exl, m_ie};
			ADDR_CAUSE:    w = {m_bd, 15'h0, m_timer, m_ext_q, m_ip_sw, 1'b0, m_code, 2'b00};
			ADDR_EPC:      w = m_epc;
			ADDR_PRID:     w = PRID;
			ADDR_CONFIG:   w = {29'h0, m_k0};
			default:       w = '0;
		endcase
	end
	return w;
endfunction

task automatic model_step();
	logic  hit;
	logic  req;
	logic  wr;
	logic  tick;
	int    first;
	word_t old_count;
	hit = m_int_hit();
	req = m_request();
	wr = valid && !hit && !excp_valid && (wa[2:0] == 3'b000);
	first = hit ? 7 : first_flag();
	tick = (m_div == DIV - 1);
	old_count = m_count;
	// divider runs freely from reset
	m_div = tick ? 0 : m_div + 1;
	if (wr && wa[7:3] == ADDR_COUNT)
		m_count = wd;
	else if (tick)
		m_count = old_count + 32'd1;
	// a Compare write clears the flag even on a match
	if (wr && wa[7:3] == ADDR_COMPARE) begin
		m_compare = wd;
		m_timer = 1'b0;
	end else if (old_count == m_compare && m_compare != '0) begin
		m_timer = 1'b1;
	end
	if (inter_valid)
		m_held = 1'b0;
	else if (req)
		m_held = 1'b1;
	if (hit || excp_valid) begin
		m_code = FLAG_CODE[first];
		// only the outermost trap records its return point
		if (!m_exl) begin
			m_epc = hit ? int_pc : (is_slot ? pc - 32'd4 : pc);
			m_bd = !hit && is_slot;
		end
		m_exl = 1'b1;
		if (first == FLAG_ADEF)
			m_badvaddr = pc;
		else if (first == FLAG_ADEL || first == FLAG_ADES)
			m_badvaddr = vaddr;
	end else if (wr) begin
		case (wa[7:3])
			ADDR_STATUS: begin
				m_im = wd[15:8];
				m_exl = wd[1];
				m_ie = wd[0];
			end
			ADDR_CAUSE:  m_ip_sw = wd[9:8];
			ADDR_EPC:    m_epc = wd;
			ADDR_CONFIG: m_k0 = wd[2:0];
			default: ;
		endcase
	end
	if (eret)
		m_exl = 1'b0;
	m_ext_q = ext_int[4:0];
endtask

`endif

// File: dv/tb_cp0.sv
module tb_cp0
	import mips_cp0_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int    DIV = 3;
	localparam word_t PRID = 32'h0001_9300;
	// masks, exceptions, interrupts and timer
	localparam int    PHASE_LEN [3] = '{300, 300, 400};
	localparam int    TOTAL_CYCLES = 5 + 300 + 300 + 400;
	localparam reg_num_t NUMS [8] = '{ADDR_BADVADDR, ADDR_COUNT, ADDR_COMPARE, ADDR_STATUS,
		ADDR_CAUSE, ADDR_EPC, ADDR_PRID, ADDR_CONFIG};

	logic        clk, reset;
	reg_addr_t   ra, wa;
	word_t       rd, wd, pc, vaddr, int_pc, epc;
	logic        valid, excp_valid, is_slot, inter_valid, eret;
	excp_flags_t excp_flags;
	logic [5:0]  ext_int;
	logic        is_intexc, is_exc;

	word_t lfsr = 32'hfb54a812;
	int    n_int;
	int    n_nest;
	int    n_timer;

	`include "tb_cp0_model.svh"

	cp0_top #(
		.COUNT_DIV(DIV),
		.PRID_VALUE(PRID)
	) u_cp0_top (.*);

	// galois lfsr, one step per bit
	function automatic word_t rnd(int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic chance(int k);
		return rnd(k) == '0;
	endfunction

	function automatic reg_addr_t pick_addr();
		reg_num_t   num;
		logic [2:0] sel;
		num = chance(2) ? reg_num_t'(rnd(5)) : NUMS[rnd(3)];
		sel = chance(2) ? 3'(rnd(3)) : 3'b000;
		return {num, sel};
	endfunction

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic drive_random(int phase);
		reg_addr_t a;
		word_t     d;
		logic      w;
		a = pick_addr();
		d = rnd(32);
		w = chance(1);
		if (phase == 2 && chance(2)) begin
			// IE set and EXL clear with a random IM
			a = {ADDR_STATUS, 3'b000};
			d = (rnd(16) << 8) | 32'h1;
			w = 1'b1;
		end else if (phase == 2 && chance(4)) begin
			// Compare a few counts ahead
			a = {ADDR_COMPARE, 3'b000};
			d = m_count + 32'd1 + rnd(2);
			w = 1'b1;
		end
		valid       <= w;
		wa          <= a;
		wd          <= d;
		ra          <= pick_addr();
		excp_valid  <= (phase == 1) ? chance(2) : (phase == 2) && chance(4);
		excp_flags  <= excp_flags_t'(rnd(7));
		pc          <= rnd(32);
		vaddr       <= rnd(32);
		is_slot     <= chance(1);
		ext_int     <= 6'(rnd(6) & rnd(6));
		inter_valid <= (phase == 2) && chance(2);
		eret        <= (phase != 0) && chance(phase == 1 ? 3 : 2);
		int_pc      <= rnd(32);
	endtask

	// outputs are checked mid-cycle, then the model moves past the edge
	task automatic check_cycle();
		@(negedge clk);
		check_flag("is_intexc", m_int_hit() || excp_valid, is_intexc);
		check_flag("is_exc", excp_valid, is_exc);
		check_word("rd", m_read(ra), rd);
		check_word("epc", m_epc, epc);
		check_word("count", m_count, u_cp0_top.count);
		if (m_int_hit())
			n_int++;
		if (excp_valid && m_exl)
			n_nest++;
		if (m_timer)
			n_timer++;
		model_step();
		@(posedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		{valid, excp_valid, is_slot, inter_valid, eret} = '0;
		{ra, wa, wd, pc, vaddr, int_pc, excp_flags, ext_int} = '0;
		model_reset();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int p = 0; p < 3; p++) begin
			for (int i = 0; i < PHASE_LEN[p]; i++) begin
				drive_random(p);
				check_cycle();
			end
		end
		if (n_int > 0 && n_nest > 0 && n_timer > 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("too few events seen: %0d interrupts, %0d nested traps, %0d timer cycles",
				n_int, n_nest, n_timer);
			abort_run();
		end
	end

	// watchdog
	initial begin
		#(TOTAL_CYCLES * 20 + 500);
		$display("timeout: the test sequence did not finish in time");
		abort_run();
	end

endmodule

// File: hdl/cp0_top.sv
module cp0_top
	import mips_cp0_pkg::*;
#(
	parameter int    COUNT_DIV  = 2,
	parameter word_t PRID_VALUE = 32'h0001_8000
) (
	input  logic        clk,
	input  logic        reset,
	input  reg_addr_t   ra,
	output word_t       rd,
	input  logic        valid,
	input  reg_addr_t   wa,
	input  word_t       wd,
	input  logic        excp_valid,
	input  excp_flags_t excp_flags,
	input  word_t       pc,
	input  word_t       vaddr,
	input  logic        is_slot,
	input  logic [5:0]  ext_int,
	input  logic        inter_valid,
	input  word_t       int_pc,
	input  logic        eret,
	output logic        is_intexc,
	output logic        is_exc,
	output word_t       epc
);

	word_t     count;
	word_t     compare;
	logic      timer_int;
	logic      status_ie;
	logic      status_exl;
	int_vec_t  status_im;
	int_vec_t  cause_ip;
	logic      take_int;
	logic      trap_take;
	exc_code_t trap_code;
	word_t     trap_epc;
	logic      trap_bd;
	logic      badvaddr_we;
	word_t     badvaddr_val;

	cp0_regs #(
		.PRID_VALUE(PRID_VALUE)
	) u_cp0_regs (
		.clk, .reset, .ra, .rd, .valid, .wa, .wd, .ext_int,
		.count, .compare, .timer_int,
		.trap_take, .trap_code, .trap_epc, .trap_bd, .badvaddr_we, .badvaddr_val,
		.eret, .epc, .status_ie, .status_exl, .status_im, .cause_ip
	);

	cp0_timer #(
		.COUNT_DIV(COUNT_DIV)
	) u_cp0_timer (
		.clk, .reset, .valid, .wa, .wd, .trap_take,
		.count, .compare, .timer_int
	);

	cp0_int_ctrl u_cp0_int_ctrl (
		.clk, .reset, .ext_int, .cause_ip,
		.status_ie, .status_exl, .status_im,
		.inter_valid, .take_int
	);

	cp0_excp_unit u_cp0_excp_unit (
		.take_int, .excp_valid, .excp_flags, .pc, .vaddr, .is_slot, .int_pc,
		.status_exl, .trap_take, .trap_code, .trap_epc, .trap_bd,
		.badvaddr_we, .badvaddr_val
	);

	assign is_intexc = trap_take;
	assign is_exc = excp_valid;

endmodule

// File: hdl/cp0_excp_unit.sv
module cp0_excp_unit
	import mips_cp0_pkg::*;
(
	input  logic        take_int,
	input  logic        excp_valid,
	input  excp_flags_t excp_flags,
	input  word_t       pc,
	input  word_t       vaddr,
	input  logic        is_slot,
	input  word_t       int_pc,
	input  logic        status_exl,
	output logic        trap_take,
	output exc_code_t   trap_code,
	output word_t       trap_epc,
	output logic        trap_bd,
	output logic        badvaddr_we,
	output word_t       badvaddr_val
);

	logic int_hit;

	// a request latched before EXL was set is dropped
	assign int_hit = take_int && !status_exl;

	assign trap_take = int_hit || excp_valid;

	// interrupt first, then flags from bit 0 up
	always_comb begin
		trap_code    = EXC_INT;
		badvaddr_we  = 1'b0;
		badvaddr_val = vaddr;
		if (int_hit) begin
			trap_code = EXC_INT;
		end else if (excp_valid) begin
			if (excp_flags[FLAG_ADEF]) begin
				trap_code    = EXC_ADEL;
				badvaddr_we  = 1'b1;
				badvaddr_val = pc;
			end else if (excp_flags[FLAG_RI]) begin
				trap_code = EXC_RI;
			end else if (excp_flags[FLAG_OV]) begin
				trap_code = EXC_OV;
			end else if (excp_flags[FLAG_BP]) begin
				trap_code = EXC_BP;
			end else if (excp_flags[FLAG_SYS]) begin
				trap_code = EXC_SYS;
			end else if (excp_flags[FLAG_ADEL]) begin
				trap_code   = EXC_ADEL;
				badvaddr_we = 1'b1;
			end else if (excp_flags[FLAG_ADES]) begin
				trap_code   = EXC_ADES;
				badvaddr_we = 1'b1;
			end
		end
	end

	// return point, only stored by cp0_regs while EXL is clear
	always_comb begin
		if (int_hit) begin
			trap_epc = int_pc;
			trap_bd  = 1'b0;
		end else if (is_slot) begin
			trap_epc = pc - 32'd4;
			trap_bd  = 1'b1;
		end else begin
			trap_epc = pc;
			trap_bd  = 1'b0;
		end
	end

	// no trap without a source from the core or from cp0_int_ctrl
	always_comb begin
		assert final (!trap_take || excp_valid || take_int);
	end

endmodule

// File: hdl/cp0_int_ctrl.sv
module cp0_int_ctrl
	import mips_cp0_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [5:0] ext_int,
	input  int_vec_t   cause_ip,
	input  logic       status_ie,
	input  logic       status_exl,
	input  int_vec_t   status_im,
	input  logic       inter_valid,
	output logic       take_int
);

	int_vec_t pending;
	logic     request;
	logic     int_held;

	// live hardware lines join the recorded IP bits
	assign pending = cause_ip | {ext_int, 2'b00};

	assign request = status_ie && !status_exl && (|(pending & status_im));

	// keeps a request until the pipeline reaches a safe point
	always_ff @(posedge clk) begin
		if (reset) begin
			int_held <= 1'b0;
		end else if (inter_valid) begin
			int_held <= 1'b0;
		end else if (request) begin
			int_held <= 1'b1;
		end
	end

	assign take_int = inter_valid && (request || int_held);

endmodule

// File: hdl/cp0_timer.sv
module cp0_timer
	import mips_cp0_pkg::*;
#(
	parameter int COUNT_DIV = 2
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      valid,
	input  reg_addr_t wa,
	input  word_t     wd,
	input  logic      trap_take,
	output word_t     count,
	output word_t     compare,
	output logic      timer_int
);

	localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic             count_we;
	logic             compare_we;

	assign tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

	assign count_we = valid && !trap_take && (wa[2:0] == 3'b000) && (wa[7:3] == ADDR_COUNT);
	assign compare_we = valid && !trap_take && (wa[2:0] == 3'b000) &&
		(wa[7:3] == ADDR_COMPARE);

	// free-running divider
	always_ff @(posedge clk) begin
		if (reset || tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count   <= '0;
			compare <= '0;
		end else begin
			if (count_we) begin
				count <= wd;
			end else if (tick) begin
				count <= count + 1'b1;
			end
			if (compare_we) begin
				compare <= wd;
			end
		end
	end

	// sticky until Compare is written again
	always_ff @(posedge clk) begin
		if (reset || compare_we) begin
			timer_int <= 1'b0;
		end else if ((count == compare) && (compare != '0)) begin
			timer_int <= 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset) int'(div_cnt) < COUNT_DIV);

endmodule

// File: hdl/cp0_regs.sv
module cp0_regs
	import mips_cp0_pkg::*;
#(
	parameter word_t PRID_VALUE = 32'h0001_8000
) (
	input  logic        clk,
	input  logic        reset,
	input  reg_addr_t   ra,
	output word_t       rd,
	input  logic        valid,
	input  reg_addr_t   wa,
	input  word_t       wd,
	input  logic [5:0]  ext_int,
	input  word_t       count,
	input  word_t       compare,
	input  logic        timer_int,
	input  logic        trap_take,
	input  exc_code_t   trap_code,
	input  word_t       trap_epc,
	input  logic        trap_bd,
	input  logic        badvaddr_we,
	input  word_t       badvaddr_val,
	input  logic        eret,
	output word_t       epc,
	output logic        status_ie,
	output logic        status_exl,
	output int_vec_t    status_im,
	output int_vec_t    cause_ip
);

	// Cause fields held here
	logic       cause_bd;
	exc_code_t  cause_code;
	logic [1:0] cause_ip_sw;
	// hardware lines IP6..IP2, sampled once per cycle
	logic [4:0] ext_q;

	word_t      epc_q;
	word_t      badvaddr_q;
	logic [2:0] config_k0;

	word_t status_word;
	word_t cause_word;
	word_t config_word;

	logic wr_en;

	// mtc0 lands only with select 0 and no trap in the same cycle
	assign wr_en = valid && !trap_take && (wa[2:0] == 3'b000);

	// IP7 is the timer, IP1..IP0 are the software bits
	assign cause_ip = {timer_int, ext_q, cause_ip_sw};

	always_comb begin
		status_word = '0;
		status_word[15:8] = status_im;
		status_word[STATUS_EXL] = status_exl;
		status_word[STATUS_IE] = status_ie;
	end

	always_comb begin
		cause_word = '0;
		cause_word[CAUSE_BD] = cause_bd;
		cause_word[15:8] = cause_ip;
		cause_word[6:2] = cause_code;
	end

	assign config_word = {CONFIG_RESET[31:3], config_k0};

	// mfc0 read mux
	always_comb begin
		rd = '0;
		if (ra[2:0] == 3'b000) begin
			case (ra[7:3])
				ADDR_BADVADDR: rd = badvaddr_q;
				ADDR_COUNT:    rd = count;
				ADDR_COMPARE:  rd = compare;
				ADDR_STATUS:   rd = status_word;
				ADDR_CAUSE:    rd = cause_word;
				ADDR_EPC:      rd = epc_q;
				ADDR_PRID:     rd = PRID_VALUE;
				ADDR_CONFIG:   rd = config_word;
				default:       rd = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ext_q <= '0;
		end else begin
			ext_q <= ext_int[4:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			status_ie   <= 1'b0;
			status_exl  <= 1'b0;
			status_im   <= '0;
			cause_bd    <= 1'b0;
			cause_code  <= '0;
			cause_ip_sw <= '0;
			epc_q       <= '0;
			badvaddr_q  <= '0;
			config_k0   <= CONFIG_RESET[2:0];
		end else begin
			if (trap_take) begin
				cause_code <= trap_code;
				status_exl <= 1'b1;
				// nested trap keeps the first return point
				if (!status_exl) begin
					epc_q    <= trap_epc;
					cause_bd <= trap_bd;
				end
				if (badvaddr_we) begin
					badvaddr_q <= badvaddr_val;
				end
			end else if (wr_en) begin
				case (wa[7:3])
					ADDR_STATUS: begin
						status_im  <= wd[15:8];
						status_exl <= wd[STATUS_EXL];
						status_ie  <= wd[STATUS_IE];
					end
					ADDR_CAUSE:  cause_ip_sw <= wd[9:8];
					ADDR_EPC:    epc_q <= wd;
					ADDR_CONFIG: config_k0 <= wd[2:0];
					default: ;
				endcase
			end
			// eret is applied last
			if (eret) begin
				status_exl <= 1'b0;
			end
		end
	end

	assign epc = epc_q;

	// the trap's EXL survives a same-cycle mtc0 to Status
	assert property (@(posedge clk) disable iff (reset)
		trap_take && !eret |=> status_exl);

endmodule

// File: hdl/mips_cp0_pkg.sv
package mips_cp0_pkg;

	// data word seen by mfc0 and mtc0
	typedef logic [31:0] word_t;

	// cp0 address, register number in [7:3] and select in [2:0]
	typedef logic [7:0] reg_addr_t;

	// register number part of a cp0 address
	typedef logic [4:0] reg_num_t;

	// Cause.ExcCode
	typedef logic [4:0] exc_code_t;

	// IP7..IP0 lines and the IM mask share this layout
	typedef logic [7:0] int_vec_t;

	// one bit per synchronous exception source
	typedef logic [6:0] excp_flags_t;

	// flag positions, bit 0 has the highest priority
	localparam int FLAG_ADEF = 0;
	localparam int FLAG_RI   = 1;
	localparam int FLAG_OV   = 2;
	localparam int FLAG_BP   = 3;
	localparam int FLAG_SYS  = 4;
	localparam int FLAG_ADEL = 5;
	localparam int FLAG_ADES = 6;

	// exception codes written to Cause.ExcCode
	localparam exc_code_t EXC_INT  = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;
	localparam exc_code_t EXC_ADES = 5'd5;
	localparam exc_code_t EXC_SYS  = 5'd8;
	localparam exc_code_t EXC_BP   = 5'd9;
	localparam exc_code_t EXC_RI   = 5'd10;
	localparam exc_code_t EXC_OV   = 5'd12;

	// register numbers
	localparam reg_num_t ADDR_BADVADDR = 5'd8;
	localparam reg_num_t ADDR_COUNT    = 5'd9;
	localparam reg_num_t ADDR_COMPARE  = 5'd11;
	localparam reg_num_t ADDR_STATUS   = 5'd12;
	localparam reg_num_t ADDR_CAUSE    = 5'd13;
	localparam reg_num_t ADDR_EPC      = 5'd14;
	localparam reg_num_t ADDR_PRID     = 5'd15;
	localparam reg_num_t ADDR_CONFIG   = 5'd16;

	// single-bit fields of Status and Cause
	localparam int STATUS_IE  = 0;
	localparam int STATUS_EXL = 1;
	localparam int CAUSE_BD   = 31;

	// Config after reset, K0 = 3 (cacheable)
	localparam word_t CONFIG_RESET = 32'h0000_0003;

endpackage
